// File: src/wcache_settings.svh
// Weight cache settings

`ifndef WCACHE_SETTINGS_SVH
`define WCACHE_SETTINGS_SVH

// Number of PE row ports
`define WCACHE_NUM_PORTS 4

// Weight RAM address and data widths
`define WCACHE_ADDR_W 13
`define WCACHE_DATA_W 8

`define WCACHE_OCH_W 6      // Output-channel tag

// Hit table entries, power of two
`define WCACHE_HIT_DEPTH 8

`endif

// File: src/wcache_pkg.sv
// Weight cache types

`default_nettype none

`include "wcache_settings.svh"

package wcache_pkg;

    // Control FSM states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CFG,
        ST_WORK,
        ST_FLUSH
    } state_e;

    // Configured opcode
    typedef enum logic {
        MODE_BYPASS,
        MODE_LOOP
    } mode_e;

    typedef logic [`WCACHE_ADDR_W-1:0]             addr_t;
    typedef logic [`WCACHE_DATA_W-1:0]             data_t;
    typedef logic [`WCACHE_OCH_W-1:0]              och_t;
    typedef logic [`WCACHE_NUM_PORTS-1:0]          port_mask_t;
    typedef logic [$clog2(`WCACHE_NUM_PORTS)-1:0]  port_idx_t;
    typedef logic [$clog2(`WCACHE_HIT_DEPTH)-1:0]  hit_idx_t;

endpackage

`default_nettype wire

// File: src/wcache_ctrl_fsm.sv
// Weight cache control FSM

`default_nettype none

module wcache_ctrl_fsm import wcache_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cfg_vld,
    input  logic       cfg_cache_ena,
    input  logic       advance,
    input  port_mask_t busy,
    output logic       cfg_rdy,
    output state_e     state,
    output mode_e      mode,
    output logic       flush
);

    state_e next_state;

    // ====================
    // State transitions
    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE:  if (cfg_vld) next_state = ST_CFG;
            ST_CFG:   next_state = ST_WORK;
            ST_WORK: begin
                if (cfg_vld) begin
                    next_state = ST_IDLE;       // Abort back to idle
                end else if (advance) begin
                    next_state = ST_FLUSH;
                end
            end
            ST_FLUSH: if (busy == '0) next_state = ST_WORK;
            default:  next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Opcode captured on the way out of CFG
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode <= MODE_BYPASS;
        end else if (state == ST_IDLE) begin
            mode <= MODE_BYPASS;
        end else if (state == ST_CFG) begin
            mode <= cfg_cache_ena ? MODE_LOOP : MODE_BYPASS;
        end
    end

    assign cfg_rdy = (state == ST_IDLE);
    assign flush   = (state == ST_WORK) && (next_state == ST_FLUSH);  // Entry pulse

    a_cfg_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) (state == ST_CFG) |=> (state != ST_CFG));

endmodule

`default_nettype wire

// File: src/filter_counter.sv
// Output-channel counter

`default_nettype none

`include "wcache_settings.svh"

module filter_counter import wcache_pkg::*; (
    input  logic                             clk,
    input  logic                             rst_n,
    input  state_e                           state,
    input  port_mask_t                       add_vld,
    input  och_t [`WCACHE_NUM_PORTS-1:0]     add_och,
    output port_mask_t                       och_match,
    output logic                             advance
);

    och_t och_cnt;

    // Tag compare per port
    always_comb begin
        for (int p = 0; p < `WCACHE_NUM_PORTS; p++) begin
            och_match[p] = (add_och[p] == och_cnt);
        end
    end

    // Every port waits on a later channel
    assign advance = (state == ST_WORK) && ((add_vld & ~och_match) == '1);

    // ====================
    // Channel count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            och_cnt <= '0;
        end else if (state == ST_IDLE) begin
            och_cnt <= '0;
        end else if (advance) begin
            och_cnt <= och_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: src/wram_port_arbiter.sv
// Weight RAM read arbiter

`default_nettype none

`include "wcache_settings.svh"

module wram_port_arbiter import wcache_pkg::*; (
    input  logic                             clk,
    input  logic                             rst_n,
    input  state_e                           state,
    input  port_mask_t                       miss_req,
    input  addr_t [`WCACHE_NUM_PORTS-1:0]    add_addr,
    input  port_mask_t                       add_lst,
    input  logic                             wram_add_rdy,
    input  logic                             wram_dat_vld,
    input  port_mask_t                       dat_rdy,
    output logic                             wram_add_vld,
    output addr_t                            wram_add_addr,
    output logic                             wram_add_lst,
    output logic                             wram_dat_rdy,
    output logic                             grant_fire,
    output port_idx_t                        grant_port,
    output port_mask_t                       multicast,
    output port_mask_t                       pending,
    output port_mask_t                       pending_lst,
    output addr_t                            pending_addr
);

    localparam int NUM_PORTS = `WCACHE_NUM_PORTS;

    port_idx_t rr_ptr;
    port_idx_t rr_next;
    logic      rd_busy;
    logic      dat_fire;

    // ====================
    // Round-robin pick
    always_comb begin : pick
        int   idx;
        logic found;
        grant_port = rr_ptr;
        found      = 1'b0;
        for (int k = 0; k < NUM_PORTS; k++) begin
            idx = (int'(rr_ptr) + k) % NUM_PORTS;
            if (!found && miss_req[idx]) begin
                grant_port = port_idx_t'(idx);
                found      = 1'b1;
            end
        end
    end

    // Ports merged into the same read
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            multicast[p] = miss_req[p] && (add_addr[p] == add_addr[grant_port]);
        end
    end

    assign rr_next = (grant_port == port_idx_t'(NUM_PORTS - 1)) ? '0 : grant_port + 1'b1;

    assign rd_busy       = |pending;
    assign wram_add_vld  = (state == ST_WORK) && (|miss_req) && !rd_busy;
    assign wram_add_addr = add_addr[grant_port];
    assign wram_add_lst  = add_lst[grant_port];
    assign grant_fire    = wram_add_vld && wram_add_rdy;

    // Answer waits for every receiving port
    assign wram_dat_rdy = rd_busy && ((dat_rdy | ~pending) == '1);
    assign dat_fire     = wram_dat_vld && wram_dat_rdy;

    // ====================
    // Outstanding read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rr_ptr      <= '0;
            pending     <= '0;
            pending_lst <= '0;
        end else if (state == ST_IDLE) begin
            rr_ptr      <= '0;
            pending     <= '0;
            pending_lst <= '0;
        end else if (grant_fire) begin
            rr_ptr      <= rr_next;
            pending     <= multicast;
            pending_lst <= add_lst & multicast;
        end else if (dat_fire) begin
            pending     <= '0;
            pending_lst <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (grant_fire) begin
            pending_addr <= wram_add_addr;
        end
    end

    // No new address while the RAM still presents an answer
    a_single_read: assert property (
        @(posedge clk) disable iff (!rst_n) wram_dat_vld |-> !wram_add_vld);

    a_grant_requests: assert property (
        @(posedge clk) disable iff (!rst_n) wram_add_vld |-> miss_req[grant_port]);

endmodule

`default_nettype wire

// File: src/hit_cache.sv
// Hit table and last-access register

`default_nettype none

`include "wcache_settings.svh"

module hit_cache import wcache_pkg::*; (
    input  logic                             clk,
    input  logic                             rst_n,
    input  state_e                           state,
    input  mode_e                            mode,
    input  logic                             flush,
    input  addr_t [`WCACHE_NUM_PORTS-1:0]    add_addr,
    input  logic                             wram_dat_fire,
    input  data_t                            wram_dat_data,
    input  addr_t                            pending_addr,
    output port_mask_t                       hit,
    output port_mask_t                       last_hit,
    output hit_idx_t [`WCACHE_NUM_PORTS-1:0] hit_index,
    output data_t [`WCACHE_HIT_DEPTH-1:0]    hit_table_data,
    output data_t                            last_data
);

    localparam int NUM_PORTS = `WCACHE_NUM_PORTS;
    localparam int DEPTH     = `WCACHE_HIT_DEPTH;

    addr_t                tag_q [DEPTH];
    logic [DEPTH-1:0]     ent_vld;
    logic [DEPTH-1:0]     pend_match;
    hit_idx_t             wr_ptr;
    addr_t                last_addr;
    logic                 last_vld;
    logic                 lookup_ena;
    logic                 last_upd;
    logic                 fill;

    assign lookup_ena = (mode == MODE_LOOP) && (state == ST_WORK);

    // ====================
    // Fill control
    always_comb begin
        for (int e = 0; e < DEPTH; e++) begin
            pend_match[e] = ent_vld[e] && (tag_q[e] == pending_addr);
        end
    end

    assign last_upd = (state == ST_WORK) && wram_dat_fire && !flush;
    assign fill     = last_upd && (mode == MODE_LOOP) && !(|pend_match);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ent_vld  <= '0;
            wr_ptr   <= '0;
            last_vld <= 1'b0;
        end else if (state == ST_IDLE || flush) begin
            ent_vld  <= '0;                    // Next filter starts cold
            wr_ptr   <= '0;
            last_vld <= 1'b0;
        end else begin
            if (fill) begin
                ent_vld[wr_ptr] <= 1'b1;
                wr_ptr          <= wr_ptr + 1'b1;   // Wraps, depth is a power of two
            end
            if (last_upd) begin
                last_vld <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_q[wr_ptr]          <= pending_addr;
            hit_table_data[wr_ptr] <= wram_dat_data;
        end
        if (last_upd) begin
            last_addr <= pending_addr;
            last_data <= wram_dat_data;
        end
    end

    // ====================
    // Per-port lookup
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            hit[p]       = 1'b0;
            hit_index[p] = '0;
            // Walk down so the lowest matching entry wins
            for (int e = DEPTH - 1; e >= 0; e--) begin
                if (ent_vld[e] && (tag_q[e] == add_addr[p])) begin
                    hit[p]       = 1'b1;
                    hit_index[p] = hit_idx_t'(e);
                end
            end
            hit[p]      = hit[p] && lookup_ena;
            last_hit[p] = lookup_ena && last_vld && (last_addr == add_addr[p]);
        end
    end

endmodule

`default_nettype wire

// File: src/port_return_stage.sv
// Per-port return stage

`default_nettype none

module port_return_stage import wcache_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  state_e state,
    input  logic   take_hit,
    input  data_t  hit_data,
    input  logic   req_lst,
    input  logic   ram_vld,
    input  data_t  ram_data,
    input  logic   ram_lst,
    input  logic   dat_rdy,
    output logic   can_take,
    output logic   busy,
    output logic   dat_vld,
    output logic   dat_lst,
    output data_t  dat_data
);

    logic  hold_vld;
    logic  hold_lst;
    data_t hold_data;

    // Held entry leaves when RAM data is not in front of it
    assign can_take = !hold_vld || (dat_rdy && !ram_vld);
    assign busy     = hold_vld;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_vld <= 1'b0;
        end else if (state == ST_IDLE) begin
            hold_vld <= 1'b0;
        end else if (can_take) begin
            hold_vld <= take_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (take_hit && can_take) begin
            hold_data <= hit_data;
            hold_lst  <= req_lst;
        end
    end

    // ====================
    // Output select
    assign dat_vld  = ram_vld || hold_vld;
    assign dat_data = ram_vld ? ram_data : hold_data;   // RAM answer first
    assign dat_lst  = ram_vld ? ram_lst : hold_lst;

    a_hold_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (dat_vld && !dat_rdy) |=> (dat_vld && $stable(dat_data) && $stable(dat_lst)));

endmodule

`default_nettype wire

// File: src/weight_cache_top.sv
// Weight cache top level

`default_nettype none

`include "wcache_settings.svh"

module weight_cache_top import wcache_pkg::*; (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             cfg_vld,
    output logic                             cfg_rdy,
    input  logic                             cfg_cache_ena,
    input  port_mask_t                       add_vld,
    input  port_mask_t                       add_lst,
    output port_mask_t                       add_rdy,
    input  addr_t [`WCACHE_NUM_PORTS-1:0]    add_addr,
    input  och_t [`WCACHE_NUM_PORTS-1:0]     add_och,
    output port_mask_t                       dat_vld,
    output port_mask_t                       dat_lst,
    input  port_mask_t                       dat_rdy,
    output data_t [`WCACHE_NUM_PORTS-1:0]    dat_data,
    output logic                             wram_add_vld,
    input  logic                             wram_add_rdy,
    output logic                             wram_add_lst,
    output addr_t                            wram_add_addr,
    input  logic                             wram_dat_vld,
    output logic                             wram_dat_rdy,
    input  data_t                            wram_dat_data
);

    state_e     state;
    mode_e      mode;
    logic       flush;
    logic       advance;
    logic       grant_fire;
    logic       wram_dat_fire;
    port_mask_t och_match, cur, cached, take_hit, miss_req;
    port_mask_t can_take, stage_busy, port_busy;
    port_mask_t hit, last_hit, multicast, pending, pending_lst;
    addr_t      pending_addr;
    data_t      last_data;
    hit_idx_t [`WCACHE_NUM_PORTS-1:0] hit_index;
    data_t [`WCACHE_HIT_DEPTH-1:0]    hit_table_data;
    data_t [`WCACHE_NUM_PORTS-1:0]    hit_data;

    // ====================
    // Request gating
    assign cur       = och_match & {`WCACHE_NUM_PORTS{state == ST_WORK}};
    assign cached    = hit | last_hit;
    assign port_busy = stage_busy | pending;   // Held data or a read in flight
    assign take_hit  = add_vld & cur & cached & can_take & ~pending;
    assign miss_req  = add_vld & cur & ~cached & ~port_busy;
    assign add_rdy   = cur & ((cached & can_take & ~pending)
                            | (multicast & {`WCACHE_NUM_PORTS{grant_fire}}));
    assign wram_dat_fire = wram_dat_vld && wram_dat_rdy;

    wcache_ctrl_fsm u_fsm (
        .clk, .rst_n, .cfg_vld, .cfg_cache_ena, .advance,
        .busy(port_busy), .cfg_rdy, .state, .mode, .flush
    );

    filter_counter u_och_cnt (
        .clk, .rst_n, .state, .add_vld, .add_och, .och_match, .advance
    );

    wram_port_arbiter u_arb (
        .clk, .rst_n, .state, .miss_req, .add_addr, .add_lst,
        .wram_add_rdy, .wram_dat_vld, .dat_rdy,
        .wram_add_vld, .wram_add_addr, .wram_add_lst, .wram_dat_rdy,
        .grant_fire, .grant_port(), .multicast, .pending, .pending_lst, .pending_addr
    );

    hit_cache u_cache (
        .clk, .rst_n, .state, .mode, .flush, .add_addr, .wram_dat_fire, .wram_dat_data,
        .pending_addr, .hit, .last_hit, .hit_index, .hit_table_data, .last_data
    );

    for (genvar p = 0; p < `WCACHE_NUM_PORTS; p++) begin : g_port
        // Last-access data preferred over the table
        assign hit_data[p] = last_hit[p] ? last_data : hit_table_data[hit_index[p]];

        port_return_stage u_ret (
            .clk, .rst_n, .state,
            .take_hit (take_hit[p]),
            .hit_data (hit_data[p]),
            .req_lst  (add_lst[p]),
            .ram_vld  (pending[p] & wram_dat_vld),
            .ram_data (wram_dat_data),
            .ram_lst  (pending_lst[p]),
            .dat_rdy  (dat_rdy[p]),
            .can_take (can_take[p]),
            .busy     (stage_busy[p]),
            .dat_vld  (dat_vld[p]),
            .dat_lst  (dat_lst[p]),
            .dat_data (dat_data[p])
        );
    end

endmodule

`default_nettype wire

// File: verif/wram_model.sv
// Behavioral weight RAM

`default_nettype none

module wram_model import wcache_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  add_vld,
    output logic  add_rdy,
    input  addr_t add_addr,
    output logic  dat_vld,
    input  logic  dat_rdy,
    output data_t dat_data,
    output int    read_count
);

    timeunit 1ns;
    timeprecision 1ps;

    logic  busy;
    logic  stall;
    int    wait_cnt;
    addr_t addr_q;

    assign add_rdy = !busy && !stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            stall      <= 1'b0;
            wait_cnt   <= 0;
            addr_q     <= '0;
            dat_vld    <= 1'b0;
            dat_data   <= '0;
            read_count <= 0;
        end else begin
            stall <= (($urandom % 4) == 0);     // Address port stalls now and then
            if (!busy) begin
                if (add_vld && add_rdy) begin
                    busy       <= 1'b1;
                    addr_q     <= add_addr;
                    wait_cnt   <= int'($urandom % 4);   // 1 to 4 cycles
                    read_count <= read_count + 1;
                end
            end else if (!dat_vld) begin
                if (wait_cnt == 0) begin
                    dat_vld  <= 1'b1;
                    dat_data <= data_t'(addr_q) ^ data_t'(8'h5a);
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end else if (dat_rdy) begin
                dat_vld <= 1'b0;
                busy    <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/weight_cache_tb.sv
// Weight cache testbench

`default_nettype none

`include "wcache_settings.svh"

module weight_cache_tb import wcache_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_PORTS  = `WCACHE_NUM_PORTS;
    localparam int CLK_PERIOD = 8;

    // One line of the vector file as a phase header or a request
    typedef struct packed {
        logic        is_phase;
        logic        mode;
        logic [15:0] reads;
        logic [7:0]  port;
        och_t        och;
        addr_t       addr;
        logic        lst;
        data_t       data;
    } vec_t;

    logic                   clk;
    logic                   rst_n;
    logic                   cfg_vld;
    logic                   cfg_rdy;
    logic                   cfg_cache_ena;
    port_mask_t             add_vld;
    port_mask_t             add_lst;
    port_mask_t             add_rdy;
    addr_t [NUM_PORTS-1:0]  add_addr;
    och_t [NUM_PORTS-1:0]   add_och;
    port_mask_t             dat_vld;
    port_mask_t             dat_lst;
    port_mask_t             dat_rdy;
    data_t [NUM_PORTS-1:0]  dat_data;
    logic                   wram_add_vld;
    logic                   wram_add_rdy;
    logic                   wram_add_lst;
    addr_t                  wram_add_addr;
    logic                   wram_dat_vld;
    logic                   wram_dat_rdy;
    data_t                  wram_dat_data;
    int                     read_count;

    vec_t  vecs[$];
    logic  vecs_loaded;
    och_t  cur_och;
    data_t exp_data [NUM_PORTS][$];     // Per-port scoreboards
    logic  exp_lst [NUM_PORTS][$];

    weight_cache_top i_dut (
        .clk, .rst_n, .cfg_vld, .cfg_rdy, .cfg_cache_ena,
        .add_vld, .add_lst, .add_rdy, .add_addr, .add_och,
        .dat_vld, .dat_lst, .dat_rdy, .dat_data,
        .wram_add_vld, .wram_add_rdy, .wram_add_lst, .wram_add_addr,
        .wram_dat_vld, .wram_dat_rdy, .wram_dat_data
    );

    wram_model i_wram (
        .clk, .rst_n,
        .add_vld  (wram_add_vld),
        .add_rdy  (wram_add_rdy),
        .add_addr (wram_add_addr),
        .dat_vld  (wram_dat_vld),
        .dat_rdy  (wram_dat_rdy),
        .dat_data (wram_dat_data),
        .read_count
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ====================
    // Failure and compare tasks
    task automatic fail_run(input string why);
        $display("Simulation failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp);
            fail_run("response data mismatch");
        end
    endtask

    task automatic check_lst(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR t=%0t %s: got %b expected %b", $time, name, got, exp);
            fail_run("response last flag mismatch");
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("ERROR t=%0t %s: got %0d expected %0d", $time, name, got, exp);
            fail_run("RAM read count mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR t=%0t %s: got %b expected %b", $time, name, got, exp);
            fail_run("control flag mismatch");
        end
    endtask

    // ====================
    // Vector file
    task automatic load_vectors();
        int    fd;
        int    f_port, f_och, f_lst, f_mode, f_reads;
        int    f_addr, f_data;
        byte   c;
        string line;
        string rest;
        vec_t  v;
        fd = $fopen("verif/weight_cache_vectors.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open verif/weight_cache_vectors.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                c    = line.getc(0);
                rest = line.substr(1, line.len() - 1);
                v    = '0;
                if (c == "P") begin
                    if ($sscanf(rest, "%d %d", f_mode, f_reads) != 2) begin
                        fail_run("malformed phase line in the vector file");
                    end
                    v.is_phase = 1'b1;
                    v.mode     = f_mode[0];
                    v.reads    = f_reads[15:0];
                    vecs.push_back(v);
                end else if (c == "R") begin
                    if ($sscanf(rest, "%d %d %h %d %h",
                                f_port, f_och, f_addr, f_lst, f_data) != 5) begin
                        fail_run("malformed request line in the vector file");
                    end
                    v.port = f_port[7:0];
                    v.och  = och_t'(f_och);
                    v.addr = addr_t'(f_addr);
                    v.lst  = f_lst[0];
                    v.data = data_t'(f_data);
                    vecs.push_back(v);
                end
            end
            $fclose(fd);
        end
    endtask

    // ====================
    // Stimulus
    task automatic configure(input logic loop_mode);
        if (!cfg_rdy) begin
            cfg_vld = 1'b1;             // Back to IDLE first
            @(posedge clk);
            #1;
            cfg_vld = 1'b0;
            @(negedge clk);
            check_flag("cfg_rdy", cfg_rdy, 1'b1);
            @(posedge clk);
            #1;
        end
        cfg_cache_ena = loop_mode;
        cfg_vld       = 1'b1;
        @(posedge clk);
        #1;
        cfg_vld = 1'b0;
        @(negedge clk);
        check_flag("cfg_rdy", cfg_rdy, 1'b0);    // CFG
        @(negedge clk);
        check_flag("cfg_rdy", cfg_rdy, 1'b0);    // WORK
        @(posedge clk);
        #1;
    endtask

    // Requests held until each one is accepted
    task automatic issue_group(input int first, input int count);
        port_mask_t waiting;
        port_mask_t taken;
        int         p;
        waiting = '0;
        for (int i = first; i < first + count; i++) begin
            p           = int'(vecs[i].port);
            add_vld[p]  = 1'b1;
            add_lst[p]  = vecs[i].lst;
            add_addr[p] = vecs[i].addr;
            add_och[p]  = vecs[i].och;
            waiting[p]  = 1'b1;
        end
        while (waiting != '0) begin
            @(negedge clk);
            taken = waiting & add_rdy;
            for (int i = first; i < first + count; i++) begin
                p = int'(vecs[i].port);
                if (taken[p]) begin
                    exp_data[p].push_back(vecs[i].data);
                    exp_lst[p].push_back(vecs[i].lst);
                end
            end
            @(posedge clk);
            #1;
            add_vld = add_vld & ~taken;
            waiting = waiting & ~taken;
        end
    endtask

    function automatic logic queues_empty();
        logic empty;
        empty = 1'b1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (exp_data[p].size() != 0) begin
                empty = 1'b0;
            end
        end
        return empty;
    endfunction

    task automatic close_phase(input int num, input int base, input int expected);
        while (!queues_empty()) begin
            @(posedge clk);
        end
        @(posedge clk);
        #1;
        check_count($sformatf("RAM reads in phase %0d", num), read_count - base, expected);
    endtask

    // PE back-pressure with ready about three cycles in four
    always @(posedge clk) begin
        #1;
        dat_rdy = port_mask_t'($urandom) | port_mask_t'($urandom);
    end

    // ====================
    // Response monitor
    always @(negedge clk) begin
        if (rst_n) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (dat_vld[p] && dat_rdy[p]) begin
                    if (exp_data[p].size() == 0) begin
                        fail_run($sformatf("port %0d returned a response with no request", p));
                    end else begin
                        check_data($sformatf("dat_data[%0d]", p), dat_data[p],
                                   exp_data[p].pop_front());
                        check_lst($sformatf("dat_lst[%0d]", p), dat_lst[p],
                                  exp_lst[p].pop_front());
                    end
                end
            end
        end
    end

    // RAM read serves an accepted request and carries its lst bit
    always @(negedge clk) begin : ram_read_monitor
        logic found;
        logic agree;
        logic first_lst;
        found     = 1'b0;
        agree     = 1'b0;
        first_lst = 1'b0;
        if (rst_n && wram_add_vld && wram_add_rdy) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (add_vld[p] && add_rdy[p] && (add_addr[p] == wram_add_addr)) begin
                    if (!found) begin
                        first_lst = add_lst[p];
                    end
                    found = 1'b1;
                    agree = agree || (add_lst[p] == wram_add_lst);
                end
            end
            if (!found) begin
                fail_run("RAM read issued with no matching accepted request");
            end else if (!agree) begin
                check_lst("wram_add_lst", wram_add_lst, first_lst);
            end
        end
    end

    initial begin : watchdog
        longint wd_cycles;
        wait (vecs_loaded);
        wd_cycles = longint'(vecs.size() + 10) * 200;
        #(wd_cycles * CLK_PERIOD);
        fail_run("watchdog expired before all vectors finished");
    end

    initial begin : main
        int   i;
        int   phase_num;
        int   phase_base;
        int   phase_reads;
        logic phase_open;
        logic configured;
        logic cur_mode;
        void'($urandom(32'hfba42840));
        clk           = 1'b0;
        rst_n         = 1'b0;
        cfg_vld       = 1'b0;
        cfg_cache_ena = 1'b0;
        add_vld       = '0;
        add_lst       = '0;
        add_addr      = '0;
        add_och       = '0;
        dat_rdy       = '0;
        vecs_loaded   = 1'b0;
        cur_och       = '0;
        load_vectors();
        vecs_loaded = 1'b1;

        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_flag("cfg_rdy", cfg_rdy, 1'b1);
        check_flag("wram_add_vld", wram_add_vld, 1'b0);
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_flag($sformatf("dat_vld[%0d]", p), dat_vld[p], 1'b0);
        end
        @(posedge clk);
        #1;

        i           = 0;
        phase_num   = 0;
        phase_base  = 0;
        phase_reads = 0;
        phase_open  = 1'b0;
        configured  = 1'b0;
        cur_mode    = 1'b0;
        while (i < vecs.size()) begin
            if (vecs[i].is_phase) begin
                if (phase_open) begin
                    close_phase(phase_num, phase_base, phase_reads);
                end
                if (!configured || vecs[i].mode != cur_mode) begin
                    configure(vecs[i].mode);
                    cur_mode   = vecs[i].mode;
                    cur_och    = '0;            // Counter restarts after config
                    configured = 1'b1;
                end
                phase_num++;
                phase_base  = read_count;
                phase_reads = int'(vecs[i].reads);
                phase_open  = 1'b1;
                i++;
            end else if (vecs[i].och != cur_och) begin
                if (i + NUM_PORTS > vecs.size()) begin
                    fail_run("filter step needs one request per port in the vector file");
                end
                issue_group(i, NUM_PORTS);      // All ports step to the next filter
                cur_och = vecs[i].och;
                i += NUM_PORTS;
            end else begin
                issue_group(i, 1);
                i++;
            end
        end
        if (phase_open) begin
            close_phase(phase_num, phase_base, phase_reads);
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/weight_cache_vectors.txt
# P <mode: 0 bypass, 1 loop> <expected RAM reads in the phase>
# R <port> <och> <addr hex> <lst> <expected data hex>
P 0 6
R 0 0 0010 0 4a
R 1 0 0010 0 4a
R 2 0 0123 0 79
R 3 0 0123 1 79
R 0 0 00ff 0 a5
R 1 0 1000 1 5a
P 1 5
R 0 0 01a5 0 ff
R 1 0 0040 0 1a
R 2 0 01a5 0 ff
R 3 0 03c7 0 9d
R 0 0 0abc 1 e6
R 1 0 1000 1 5a
P 1 0
R 3 0 0040 0 1a
R 2 0 03c7 0 9d
R 1 0 01a5 1 ff
R 0 0 1000 0 5a
R 0 0 0abc 1 e6
P 1 4
R 0 1 01a5 0 ff
R 1 1 0040 0 1a
R 2 1 03c7 0 9d
R 3 1 1000 1 5a
R 2 1 0040 1 1a

// File: files.f
+incdir+src
src/wcache_pkg.sv
src/wcache_ctrl_fsm.sv
src/filter_counter.sv
src/wram_port_arbiter.sv
src/hit_cache.sv
src/port_return_stage.sv
src/weight_cache_top.sv
verif/wram_model.sv
verif/weight_cache_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the weight cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module weight_cache_tb \
    -f files.f \
    -o weight_cache_sim

./obj_dir/weight_cache_sim
